/* test/exec_trace.txt */
# funct7 funct3 r1 r2 tag expected flag, all hex
# flag 0 no result, 1 result, 2 isolated with latency check, 3 timed to finish with the divide
00 0 00000005 00000007 1 0000000c 2
20 0 00000005 00000007 2 fffffffe 1
00 1 00000001 00000024 3 00000010 1
00 5 80000000 0000001f 4 00000001 1
20 5 80000000 00000024 5 f8000000 1
00 4 ff00ff00 0f0f0f0f 6 f00ff00f 1
00 6 ff00ff00 0f0f0f0f 7 ff0fff0f 1
00 7 ff00ff00 0f0f0f0f 8 0f000f00 1
01 1 fffffffe 00000003 9 ffffffff 2
01 0 80000000 ffffffff a 80000000 1
01 1 80000000 80000000 b 40000000 1
01 2 80000000 ffffffff c 80000000 1
01 3 ffffffff ffffffff d fffffffe 1
01 4 fffffff9 00000002 e fffffffd 2
01 6 fffffff9 00000002 f ffffffff 1
01 5 00000064 00000007 1 0000000e 1
01 7 00000064 00000007 2 00000002 1
01 4 00001234 00000000 3 ffffffff 1
01 6 fffffff6 00000000 4 fffffff6 1
01 5 00000064 00000000 5 ffffffff 1
01 7 00000064 00000000 6 00000064 1
01 4 80000000 ffffffff 7 80000000 1
01 6 80000000 ffffffff 8 00000000 1
01 4 0000fff0 00000010 9 00000fff 1
00 0 00000001 00000002 a 00000003 1
01 0 00000003 00000004 b 0000000c 1
20 0 00000000 00000001 c ffffffff 1
01 3 80000000 00000002 d 00000001 1
01 0 fffffffd 00000005 e fffffff1 3
00 4 aaaaaaaa 55555555 f ffffffff 3
02 0 00000001 00000001 1 00000000 0
00 2 00000001 00000002 2 00000000 0
20 3 00000001 00000002 3 00000000 0
00 0 7fffffff 00000001 4 80000000 1

/* verilog.f */
logic/rv32i_pkg.sv
logic/exec_pkg.sv
logic/op_dispatch.sv
logic/mul_unit.sv
logic/div_unit.sv
logic/result_merge.sv
logic/exec_unit.sv
test/clock_gen.sv
test/exec_unit_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := exec_unit_tb
FILELIST  := verilog.f

BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf $(BUILD_DIR)

/* test/exec_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit_tb;

	localparam int drive_delay = 2;
	localparam int div_latency = 35;

	logic              clk;
	logic              rst_n;
	exec_pkg::issue_t  issue;
	exec_pkg::result_t result;
	logic              div_busy;

	// scoreboard by tag where state 0 is free, 1 waiting and 2 must stay silent
	int              tag_state [16];
	exec_pkg::word_t tag_expect [16];
	int              tag_issue_cyc [16];
	int              tag_latency [16];
	bit              tag_isolated [16];
	string           tag_name [16];

	int cyc;
	int outstanding;
	int last_div_cyc;
	int value_errors;
	int protocol_errors;
	int timeout_errors;

	clock_gen i_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	exec_unit i_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.issue    (issue),
		.result   (result),
		.div_busy (div_busy)
	);

	// end-to-end latency of an isolated operation
	function automatic int op_latency(input logic [6:0] f7, input logic [2:0] f3);
		if (f7 == rv32i_pkg::f7_muldiv)
			return f3[2] ? div_latency : 4;
		return 2;
	endfunction

	task automatic check_result();
		exec_pkg::tag_t t;
		if (result.valid) begin
			t = result.tag;
			assert (tag_state[t] == 1) else begin
				if (tag_state[t] == 2)
					$display("%s returned a result but should produce none", tag_name[t]);
				else
					$display("result with tag %0d arrived while nothing waits on it", t);
				protocol_errors++;
			end
			if (tag_state[t] == 1) begin
				assert (result.data == tag_expect[t]) else begin
					$display("MISMATCH %s: expected %h, actual %h",
						tag_name[t], tag_expect[t], result.data);
					value_errors++;
				end
				if (tag_isolated[t]) begin
					assert (cyc - tag_issue_cyc[t] == tag_latency[t]) else begin
						$display("MISMATCH %s latency: expected %0d, actual %0d",
							tag_name[t], tag_latency[t], cyc - tag_issue_cyc[t]);
						value_errors++;
					end
				end
				tag_state[t] = 0;
				outstanding--;
			end
		end
	endtask

	// results are sampled mid-cycle and inputs change just after the rising edge
	task automatic next_cycle();
		@(negedge clk);
		check_result();
		@(posedge clk);
		#drive_delay;
		cyc++;
	endtask

	task automatic drain_results(input int limit);
		int n;
		n = 0;
		while (outstanding != 0 && n < limit) begin
			next_cycle();
			n++;
		end
		assert (outstanding == 0) else begin
			$display("%0d results still missing after %0d cycles", outstanding, limit);
			timeout_errors++;
		end
	endtask

	task automatic wait_divider_free();
		int n;
		n = 0;
		// busy rises two cycles after a divide is issued
		while ((div_busy || cyc < last_div_cyc + 2) && n < 100) begin
			next_cycle();
			n++;
		end
		assert (!div_busy) else begin
			$display("divider still busy after 100 cycles");
			timeout_errors++;
		end
	endtask

	task automatic wait_tag_free(input exec_pkg::tag_t t);
		int n;
		n = 0;
		while (tag_state[t] == 1 && n < 100) begin
			next_cycle();
			n++;
		end
		assert (tag_state[t] != 1) else begin
			$display("tag %0d never returned, cannot reuse it", t);
			timeout_errors++;
		end
	endtask

	// issue so the result reaches the merge together with the running divide
	task automatic align_with_divide(input int lat);
		int n;
		int target;
		target = last_div_cyc + div_latency - lat;
		assert (cyc <= target) else begin
			$display("too late to finish with the divide, cycle %0d, target %0d", cyc, target);
			protocol_errors++;
		end
		n = 0;
		while (cyc < target && n < 100) begin
			next_cycle();
			n++;
		end
		assert (cyc >= target) else begin
			$display("alignment wait ran out of cycles");
			timeout_errors++;
		end
	endtask

	task automatic issue_op(
		input logic [6:0]      f7,
		input logic [2:0]      f3,
		input exec_pkg::word_t r1,
		input exec_pkg::word_t r2,
		input exec_pkg::tag_t  tag,
		input exec_pkg::word_t exp_val,
		input int              flag,
		input int              line_no
	);
		tag_name[tag]      = $sformatf("trace line %0d", line_no);
		tag_expect[tag]    = exp_val;
		tag_issue_cyc[tag] = cyc;
		tag_latency[tag]   = op_latency(f7, f3);
		tag_isolated[tag]  = (flag == 2);
		if (flag == 0) begin
			tag_state[tag] = 2;
		end else begin
			tag_state[tag] = 1;
			outstanding++;
		end
		if (f7 == rv32i_pkg::f7_muldiv && f3[2])
			last_div_cyc = cyc;
		issue.valid  = 1'b1;
		issue.funct7 = f7;
		issue.funct3 = f3;
		issue.r1     = r1;
		issue.r2     = r2;
		issue.tag    = tag;
		next_cycle();
		issue = '0;
	endtask

	task automatic finish_isolated(input exec_pkg::tag_t t, input bit is_div);
		int n;
		int age;
		n = 0;
		while (tag_state[t] == 1 && n < 100) begin
			age = cyc - tag_issue_cyc[t];
			if (is_div && age >= 2 && age < div_latency) begin
				assert (div_busy) else begin
					$display("div_busy low %0d cycles into %s", age, tag_name[t]);
					protocol_errors++;
				end
			end
			next_cycle();
			n++;
		end
		assert (tag_state[t] != 1) else begin
			$display("%s gave no result within 100 cycles", tag_name[t]);
			timeout_errors++;
		end
	endtask

	initial begin
		int              fd;
		int              n;
		int              n_fields;
		int              flag;
		int              gap;
		int              line_no;
		string           text;
		logic [6:0]      f7;
		logic [2:0]      f3;
		exec_pkg::word_t r1;
		exec_pkg::word_t r2;
		exec_pkg::word_t exp_val;
		exec_pkg::tag_t  tag;
		bit              is_div;

		issue           = '0;
		cyc             = 0;
		outstanding     = 0;
		last_div_cyc    = -100;
		value_errors    = 0;
		protocol_errors = 0;
		timeout_errors  = 0;
		void'($urandom(98337));

		n = 0;
		while (rst_n !== 1'b1 && n < 50) begin
			@(negedge clk);
			n++;
		end
		assert (rst_n === 1'b1) else begin
			$display("reset was never released");
			timeout_errors++;
		end
		@(posedge clk);
		#drive_delay;

		for (int i = 0; i < 5; i++) begin
			assert (!result.valid && !div_busy) else begin
				$display("result.valid or div_busy high after reset with nothing issued");
				protocol_errors++;
			end
			next_cycle();
		end

		fd = $fopen("test/exec_trace.txt", "r");
		assert (fd != 0) else begin
			$display("cannot open test/exec_trace.txt");
			protocol_errors++;
		end
		line_no = 0;
		while (fd != 0 && !$feof(fd)) begin
			text = "";
			n = $fgets(text, fd);
			line_no++;
			n_fields = $sscanf(text, "%h %h %h %h %h %h %h", f7, f3, r1, r2, tag, exp_val, flag);
			if (n == 0 || n_fields != 7)
				continue;
			is_div = (f7 == rv32i_pkg::f7_muldiv) && f3[2];
			if (flag == 2) begin
				drain_results(100);
			end else if (flag == 3) begin
				align_with_divide(op_latency(f7, f3));
			end else begin
				gap = $urandom % 4;
				for (int i = 0; i < gap; i++)
					next_cycle();
			end
			if (is_div)
				wait_divider_free();
			wait_tag_free(tag);
			issue_op(f7, f3, r1, r2, tag, exp_val, flag, line_no);
			if (flag == 2)
				finish_isolated(tag, is_div);
		end
		if (fd != 0)
			$fclose(fd);

		drain_results(200);
		// a stray result from a silent op would show up here
		for (int i = 0; i < div_latency + 5; i++)
			next_cycle();

		$display("errors: %0d mismatches, %0d protocol, %0d timeouts",
			value_errors, protocol_errors, timeout_errors);
		if (value_errors + protocol_errors + timeout_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* test/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
	output logic clk,
	output logic rst_n
);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		#2;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* logic/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
	input  logic              clk,
	input  logic              rst_n,
	input  exec_pkg::issue_t  issue,
	output exec_pkg::result_t result,
	output logic              div_busy
);

	exec_pkg::result_t  int_res;
	exec_pkg::mul_req_t mul_req;
	exec_pkg::div_req_t div_req;
	exec_pkg::result_t  mul_res;
	exec_pkg::result_t  div_res;

	op_dispatch i_dispatch (
		.clk     (clk),
		.rst_n   (rst_n),
		.issue   (issue),
		.int_res (int_res),
		.mul_req (mul_req),
		.div_req (div_req)
	);

	mul_unit i_mul (
		.clk     (clk),
		.rst_n   (rst_n),
		.mul_req (mul_req),
		.mul_res (mul_res)
	);

	div_unit i_div (
		.clk      (clk),
		.rst_n    (rst_n),
		.div_req  (div_req),
		.div_res  (div_res),
		.div_busy (div_busy)
	);

	result_merge i_merge (
		.clk     (clk),
		.rst_n   (rst_n),
		.int_res (int_res),
		.mul_res (mul_res),
		.div_res (div_res),
		.result  (result)
	);

endmodule

`default_nettype wire

/* logic/result_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module result_merge (
	input  logic              clk,
	input  logic              rst_n,
	input  exec_pkg::result_t int_res,
	input  exec_pkg::result_t mul_res,
	input  exec_pkg::result_t div_res,
	output exec_pkg::result_t result
);

	exec_pkg::word_t data_mem [4];
	exec_pkg::tag_t  tag_mem [4];
	logic [1:0]      wr_ptr;
	logic [1:0]      rd_ptr;
	logic [2:0]      count;
	logic [1:0]      off_mul;
	logic [1:0]      off_int;
	logic [2:0]      n_in;
	logic            pop;
	exec_pkg::word_t first_data;
	exec_pkg::tag_t  first_tag;

	// slot offsets follow the fixed order div, mul, integer
	assign off_mul = {1'b0, div_res.valid};
	assign off_int = off_mul + {1'b0, mul_res.valid};
	assign n_in    = {1'b0, off_int} + {2'b00, int_res.valid};
	assign pop     = (count != 3'd0) || (n_in != 3'd0);

	// empty queue lets the first arrival through in the same edge
	always_comb begin
		if (div_res.valid) begin
			first_data = div_res.data;
			first_tag  = div_res.tag;
		end else if (mul_res.valid) begin
			first_data = mul_res.data;
			first_tag  = mul_res.tag;
		end else begin
			first_data = int_res.data;
			first_tag  = int_res.tag;
		end
	end

	always_ff @(posedge clk) begin
		if (div_res.valid) begin
			data_mem[wr_ptr] <= div_res.data;
			tag_mem[wr_ptr]  <= div_res.tag;
		end
		if (mul_res.valid) begin
			data_mem[wr_ptr + off_mul] <= mul_res.data;
			tag_mem[wr_ptr + off_mul]  <= mul_res.tag;
		end
		if (int_res.valid) begin
			data_mem[wr_ptr + off_int] <= int_res.data;
			tag_mem[wr_ptr + off_int]  <= int_res.tag;
		end

		if (count != 3'd0) begin
			result.data <= data_mem[rd_ptr];
			result.tag  <= tag_mem[rd_ptr];
		end else begin
			result.data <= first_data;
			result.tag  <= first_tag;
		end

		if (!rst_n) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			count        <= '0;
			result.valid <= 1'b0;
		end else begin
			wr_ptr       <= wr_ptr + n_in[1:0];
			rd_ptr       <= rd_ptr + {1'b0, pop};
			count        <= count + n_in - {2'b00, pop};
			result.valid <= pop;
		end
	end

endmodule

`default_nettype wire

/* logic/div_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module div_unit (
	input  logic               clk,
	input  logic               rst_n,
	input  exec_pkg::div_req_t div_req,
	output exec_pkg::result_t  div_res,
	output logic               div_busy
);

	typedef enum logic [1:0] {div_idle, div_run, div_fix} div_state_e;

	div_state_e      state;
	logic [4:0]      step;
	exec_pkg::word_t rem_q;
	exec_pkg::word_t quo_q;
	exec_pkg::word_t dvs_q;
	logic            quo_neg;
	logic            rem_neg;
	logic            want_rem;
	exec_pkg::tag_t  tag_q;
	exec_pkg::word_t src_rem;
	exec_pkg::word_t src_quo;
	exec_pkg::word_t src_dvs;
	logic [32:0]     shifted;
	logic [33:0]     diff;
	exec_pkg::word_t nxt_rem;
	exec_pkg::word_t nxt_quo;
	exec_pkg::word_t final_val;

	// first step runs on the incoming request while idle
	always_comb begin
		if (state == div_idle) begin
			src_rem = '0;
			src_quo = div_req.a;
			src_dvs = div_req.b;
		end else begin
			src_rem = rem_q;
			src_quo = quo_q;
			src_dvs = dvs_q;
		end
		shifted = {src_rem, src_quo[31]};
		diff    = {1'b0, shifted} - {2'b00, src_dvs};
		if (!diff[33]) begin
			nxt_rem = diff[31:0];
			nxt_quo = {src_quo[30:0], 1'b1};
		end else begin
			nxt_rem = shifted[31:0];
			nxt_quo = {src_quo[30:0], 1'b0};
		end
	end

	always_comb begin
		if (want_rem)
			final_val = rem_neg ? (~rem_q + 32'd1) : rem_q;
		else
			final_val = quo_neg ? (~quo_q + 32'd1) : quo_q;
	end

	assign div_busy = (state != div_idle) | div_res.valid;

	always_ff @(posedge clk) begin
		case (state)
			div_idle: begin
				if (div_req.valid) begin
					dvs_q    <= div_req.b;
					quo_neg  <= div_req.negate_quo;
					rem_neg  <= div_req.negate_rem;
					want_rem <= div_req.want_rem;
					tag_q    <= div_req.tag;
					rem_q    <= nxt_rem;
					quo_q    <= nxt_quo;
					step     <= 5'd1;
				end
			end
			div_run: begin
				rem_q <= nxt_rem;
				quo_q <= nxt_quo;
				step  <= step + 5'd1;
			end
			default: ;
		endcase

		div_res.data <= final_val;
		div_res.tag  <= tag_q;

		if (!rst_n) begin
			state         <= div_idle;
			div_res.valid <= 1'b0;
		end else begin
			div_res.valid <= (state == div_fix);
			case (state)
				div_idle: if (div_req.valid) state <= div_run;
				// steps 2 to 32
				div_run:  if (step == 5'd31) state <= div_fix;
				default:  state <= div_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
	input  logic               clk,
	input  logic               rst_n,
	input  exec_pkg::mul_req_t mul_req,
	output exec_pkg::result_t  mul_res
);

	logic [63:0]    prod;
	logic [63:0]    signed_prod;
	logic           s1_valid;
	logic           s1_neg;
	logic           s1_high;
	exec_pkg::tag_t s1_tag;

	assign signed_prod = s1_neg ? (~prod + 64'd1) : prod;

	always_ff @(posedge clk) begin
		// stage one forms the unsigned product of the magnitudes
		prod    <= {32'd0, mul_req.a} * {32'd0, mul_req.b};
		s1_neg  <= mul_req.negate;
		s1_high <= mul_req.take_high;
		s1_tag  <= mul_req.tag;

		// stage two restores the sign and selects the word
		mul_res.data <= s1_high ? signed_prod[63:32] : signed_prod[31:0];
		mul_res.tag  <= s1_tag;

		if (!rst_n) begin
			s1_valid      <= 1'b0;
			mul_res.valid <= 1'b0;
		end else begin
			s1_valid      <= mul_req.valid;
			mul_res.valid <= s1_valid;
		end
	end

endmodule

`default_nettype wire

/* logic/op_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module op_dispatch (
	input  logic               clk,
	input  logic               rst_n,
	input  exec_pkg::issue_t   issue,
	output exec_pkg::result_t  int_res,
	output exec_pkg::mul_req_t mul_req,
	output exec_pkg::div_req_t div_req
);

	rv32i_pkg::funct7_e f7;
	rv32i_pkg::alu_op_e alu_op;
	rv32i_pkg::md_op_e  md_op;
	exec_pkg::word_t    alu_val;
	exec_pkg::word_t    mag_a;
	exec_pkg::word_t    mag_b;
	logic               alu_hit;
	logic               mul_hit;
	logic               div_hit;
	logic               signed_a;
	logic               signed_b;
	logic               neg_a;
	logic               neg_b;

	assign f7     = rv32i_pkg::funct7_e'(issue.funct7);
	assign alu_op = rv32i_pkg::alu_op_e'(issue.funct3);
	assign md_op  = rv32i_pkg::md_op_e'(issue.funct3);

	// which operands are read as two's complement
	assign signed_a = (md_op == rv32i_pkg::md_mulh) || (md_op == rv32i_pkg::md_mulhsu) ||
		(md_op == rv32i_pkg::md_div) || (md_op == rv32i_pkg::md_rem);
	assign signed_b = (md_op == rv32i_pkg::md_mulh) || (md_op == rv32i_pkg::md_div) ||
		(md_op == rv32i_pkg::md_rem);

	assign neg_a = signed_a & issue.r1[31];
	assign neg_b = signed_b & issue.r2[31];
	assign mag_a = neg_a ? (~issue.r1 + 32'd1) : issue.r1;
	assign mag_b = neg_b ? (~issue.r2 + 32'd1) : issue.r2;

	always_comb begin
		alu_val = '0;
		alu_hit = 1'b0;
		mul_hit = 1'b0;
		div_hit = 1'b0;
		if (issue.valid) begin
			case (f7)
				rv32i_pkg::f7_base, rv32i_pkg::f7_alt: begin
					alu_hit = 1'b1;
					case (alu_op)
						rv32i_pkg::alu_add: begin
							if (f7 == rv32i_pkg::f7_alt)
								alu_val = issue.r1 - issue.r2;
							else
								alu_val = issue.r1 + issue.r2;
						end
						rv32i_pkg::alu_sll: alu_val = issue.r1 << issue.r2[4:0];
						rv32i_pkg::alu_srl: begin
							// arithmetic shift under f7_alt
							if (f7 == rv32i_pkg::f7_alt)
								alu_val = $signed(issue.r1) >>> issue.r2[4:0];
							else
								alu_val = issue.r1 >> issue.r2[4:0];
						end
						rv32i_pkg::alu_xor: alu_val = issue.r1 ^ issue.r2;
						rv32i_pkg::alu_or:  alu_val = issue.r1 | issue.r2;
						rv32i_pkg::alu_and: alu_val = issue.r1 & issue.r2;
						default: alu_hit = 1'b0;
					endcase
				end
				rv32i_pkg::f7_muldiv: begin
					// funct3 bit 2 separates divide from multiply
					mul_hit = ~issue.funct3[2];
					div_hit = issue.funct3[2];
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		int_res.data <= alu_val;
		int_res.tag  <= issue.tag;

		mul_req.a         <= mag_a;
		mul_req.b         <= mag_b;
		mul_req.negate    <= neg_a ^ neg_b;
		mul_req.take_high <= (md_op != rv32i_pkg::md_mul);
		mul_req.tag       <= issue.tag;

		div_req.a          <= mag_a;
		div_req.b          <= mag_b;
		// the quotient of x / 0 stays all ones and is never negated
		div_req.negate_quo <= (neg_a ^ neg_b) & (issue.r2 != 32'd0);
		div_req.negate_rem <= neg_a;
		div_req.want_rem   <= issue.funct3[1];
		div_req.tag        <= issue.tag;

		if (!rst_n) begin
			int_res.valid <= 1'b0;
			mul_req.valid <= 1'b0;
			div_req.valid <= 1'b0;
		end else begin
			int_res.valid <= alu_hit;
			mul_req.valid <= mul_hit;
			div_req.valid <= div_hit;
		end
	end

endmodule

`default_nettype wire

/* logic/exec_pkg.sv */
`default_nettype none

package exec_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0]  tag_t;

	// one issued operation with raw funct fields that may carry unknown codes
	typedef struct packed {
		logic       valid;
		logic [6:0] funct7;
		logic [2:0] funct3;
		word_t      r1;
		word_t      r2;
		tag_t       tag;
	} issue_t;

	// operands are magnitudes and the sign is restored after the multiply
	typedef struct packed {
		logic  valid;
		word_t a;
		word_t b;
		logic  negate;
		logic  take_high;
		tag_t  tag;
	} mul_req_t;

	typedef struct packed {
		logic  valid;
		word_t a;
		word_t b;
		logic  negate_quo;
		logic  negate_rem;
		logic  want_rem;
		tag_t  tag;
	} div_req_t;

	typedef struct packed {
		logic  valid;
		word_t data;
		tag_t  tag;
	} result_t;

endpackage

`default_nettype wire

/* logic/rv32i_pkg.sv */
`default_nettype none

package rv32i_pkg;

	// funct7 classes of the register-register ops
	typedef enum logic [6:0] {
		f7_base   = 7'b0000000,
		f7_alt    = 7'b0100000,
		f7_muldiv = 7'b0000001
	} funct7_e;

	// funct3 under f7_base and f7_alt
	// 010 and 011 (slt/sltu) are not handled
	typedef enum logic [2:0] {
		alu_add = 3'b000,
		alu_sll = 3'b001,
		alu_xor = 3'b100,
		alu_srl = 3'b101,
		alu_or  = 3'b110,
		alu_and = 3'b111
	} alu_op_e;

	// funct3 under f7_muldiv
	typedef enum logic [2:0] {
		md_mul    = 3'b000,
		md_mulh   = 3'b001,
		md_mulhsu = 3'b010,
		md_mulhu  = 3'b011,
		md_div    = 3'b100,
		md_divu   = 3'b101,
		md_rem    = 3'b110,
		md_remu   = 3'b111
	} md_op_e;

endpackage

`default_nettype wire
